// ==== src/panel_macros.svh ====
/* Panel geometry shared by RTL and testbench.
   Height, width and bytes per pixel must each be 2 or more and at most 255. */
`ifndef PANEL_MACROS_SVH
`define PANEL_MACROS_SVH

// Columns
`define PANEL_WIDTH 64

// Rows
`define PANEL_HEIGHT 32

// Colour bytes per pixel
`define BYTES_PER_PIXEL 3

`endif

// ==== src/panel_pkg.sv ====
/* Address, colour and command types for the panel frame writer.
   Fill requests in fill_req_t are already clipped to the panel. */
`include "panel_macros.svh"

package panel_pkg;

    typedef logic [$clog2(`PANEL_HEIGHT)-1:0] row_t;
    typedef logic [$clog2(`PANEL_WIDTH)-1:0] column_t;
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0] pixel_t;

    // Byte 0 lands at pixel index 0
    typedef logic [`BYTES_PER_PIXEL-1:0][7:0] color_t;

    typedef enum logic [7:0] {
        OP_BLANK = 8'h01,
        OP_FILL  = 8'h02
    } opcode_e;

    typedef struct packed {
        column_t x1;
        row_t y1;
        logic [7:0] width;   // Never zero
        logic [7:0] height;  // Never zero
        color_t color;
    } fill_req_t;

endpackage

// ==== src/fb_write_if.sv ====
/* One byte write into the frame buffer per cycle with write_enable high.
   No handshake, the memory always accepts. */
`timescale 1ns/1ps

interface fb_write_if;

    panel_pkg::row_t row;
    panel_pkg::column_t column;
    panel_pkg::pixel_t pixel;    // Byte within the pixel
    logic [7:0] data;
    logic write_enable;

    modport writer (
        output row, column, pixel, data, write_enable
    );

    modport memory (
        input row, column, pixel, data, write_enable
    );

endinterface

// ==== src/cmd_decoder.sv ====
/* Bytes arriving while busy are dropped, there is no back-pressure.
   Out-of-panel origins and zero sizes are discarded without a cmd_done. */
`timescale 1ns/1ps
`include "panel_macros.svh"

module cmd_decoder (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] cmd_byte,
    input  logic cmd_valid,
    input  logic fill_done,
    output logic fill_enable,
    output panel_pkg::fill_req_t fill_req,
    output logic busy,
    output logic cmd_done
);
    localparam int NUM_ARGS = 4 + `BYTES_PER_PIXEL;
    localparam int CNT_W = $clog2(NUM_ARGS);

    typedef enum logic [1:0] {S_OPCODE, S_ARGS, S_BUSY} state_e;

    state_e state;
    logic [CNT_W-1:0] arg_count;
    logic [7:0] x1_raw, y1_raw, width_raw, height_raw;
    panel_pkg::color_t color_buf, color_next;
    logic [8:0] room_x, room_y;
    logic [7:0] eff_width, eff_height;
    logic accept, cmd_ok;

    assign accept = cmd_valid && !busy;
    assign busy = (state == S_BUSY);
    assign fill_enable = busy;
    assign cmd_done = fill_done;

    // Space left from the origin to the panel edge
    assign room_x = 9'(`PANEL_WIDTH) - {1'b0, x1_raw};
    assign room_y = 9'(`PANEL_HEIGHT) - {1'b0, y1_raw};
    assign eff_width = ({1'b0, width_raw} > room_x) ? room_x[7:0] : width_raw;
    assign eff_height = ({1'b0, height_raw} > room_y) ? room_y[7:0] : height_raw;
    assign cmd_ok = (x1_raw < `PANEL_WIDTH) && (y1_raw < `PANEL_HEIGHT) &&
                    (width_raw != 8'd0) && (height_raw != 8'd0);

    always_comb begin
        color_next = color_buf;
        color_next[`BYTES_PER_PIXEL-1] = cmd_byte;  // Last byte is still on the bus
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_OPCODE;
            arg_count <= '0;
        end else begin
            case (state)
                S_OPCODE: if (accept) begin
                    arg_count <= '0;
                    if (cmd_byte == panel_pkg::OP_BLANK) begin
                        fill_req <= '{x1: '0, y1: '0, width: 8'(`PANEL_WIDTH),
                                      height: 8'(`PANEL_HEIGHT), color: '0};
                        state <= S_BUSY;
                    end else if (cmd_byte == panel_pkg::OP_FILL) begin
                        state <= S_ARGS;
                    end
                end
                S_ARGS: if (accept) begin
                    case (arg_count)
                        0: x1_raw <= cmd_byte;
                        1: y1_raw <= cmd_byte;
                        2: width_raw <= cmd_byte;
                        3: height_raw <= cmd_byte;
                        default: color_buf[arg_count - CNT_W'(4)] <= cmd_byte;
                    endcase
                    if (arg_count == CNT_W'(NUM_ARGS - 1)) begin
                        fill_req <= '{x1: panel_pkg::column_t'(x1_raw),
                                      y1: panel_pkg::row_t'(y1_raw),
                                      width: eff_width, height: eff_height,
                                      color: color_next};
                        state <= cmd_ok ? S_BUSY : S_OPCODE;
                    end else begin
                        arg_count <= arg_count + 1'b1;
                    end
                end
                S_BUSY: if (fill_done) state <= S_OPCODE;
                default: state <= S_OPCODE;
            endcase
        end
    end

    // Request holds for the whole fill and stays on the panel
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        fill_enable |-> (!$past(fill_enable) || $stable(fill_req)) &&
                        (fill_req.width != 8'd0) && (fill_req.height != 8'd0) &&
                        (int'(fill_req.x1) + int'(fill_req.width) <= `PANEL_WIDTH) &&
                        (int'(fill_req.y1) + int'(fill_req.height) <= `PANEL_HEIGHT));

endmodule

// ==== src/fill_area_engine.sv ====
/* Sweeps pixel bytes fastest, then columns, then rows, one write per cycle.
   Expects a request clipped to the panel; starts once per reset. */
`timescale 1ns/1ps
`include "panel_macros.svh"

module fill_area_engine (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic ack,
    input  panel_pkg::fill_req_t req,
    output logic engine_done,
    fb_write_if.writer wr
);
    logic active;
    logic [7:0] x_off, y_off;
    panel_pkg::pixel_t pix;
    logic last_pix, last_col, last_row;

    assign last_pix = (pix == panel_pkg::pixel_t'(`BYTES_PER_PIXEL - 1));
    assign last_col = (x_off == req.width - 8'd1);
    assign last_row = (y_off == req.height - 8'd1);

    assign wr.write_enable = active;
    assign wr.row = panel_pkg::row_t'(req.y1 + y_off);
    assign wr.column = panel_pkg::column_t'(req.x1 + x_off);
    assign wr.pixel = pix;
    assign wr.data = req.color[pix];

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            engine_done <= 1'b0;
            x_off <= '0;
            y_off <= '0;
            pix <= '0;
        end else begin
            if (ack) engine_done <= 1'b0;

            if (active) begin
                if (!last_pix) begin
                    pix <= pix + 1'b1;
                end else begin
                    pix <= '0;
                    if (!last_col) begin
                        x_off <= x_off + 8'd1;
                    end else begin
                        x_off <= '0;
                        if (!last_row) begin
                            y_off <= y_off + 8'd1;
                        end else begin
                            active <= 1'b0;    // Final byte this cycle
                            engine_done <= 1'b1;
                        end
                    end
                end
            end else if (run && !engine_done) begin
                active <= 1'b1;
                x_off <= '0;
                y_off <= '0;
                pix <= '0;
            end
        end
    end

    // Clipping upstream keeps every write on the panel
    a_in_panel: assert property (@(posedge clk) disable iff (reset)
        wr.write_enable |-> (int'(req.y1) + int'(y_off) < `PANEL_HEIGHT) &&
                            (int'(req.x1) + int'(x_off) < `PANEL_WIDTH));

endmodule

// ==== src/area_fill_cmd.sv ====
/* Runs one fill request per enable level through a fresh engine.
   done is a single-cycle pulse, enable must drop on it. */
`timescale 1ns/1ps

module area_fill_cmd (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  panel_pkg::fill_req_t req,
    output logic done,
    fb_write_if.writer wr
);
    typedef enum logic [1:0] {
        ST_START,
        ST_RUNNING,
        ST_PREDONE,
        ST_DONE
    } ctrl_state_e;

    ctrl_state_e state;
    logic run;
    logic local_reset;     // Clears the engine after each request
    logic engine_reset;
    logic engine_done;

    assign engine_reset = reset || local_reset;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_START;
            run <= 1'b0;
            done <= 1'b0;
            local_reset <= 1'b0;
        end else begin
            case (state)
                ST_START: if (enable) begin
                    run <= 1'b1;
                    state <= ST_RUNNING;
                end
                ST_RUNNING: if (engine_done) begin
                    run <= 1'b0;
                    state <= ST_PREDONE;
                end
                ST_PREDONE: begin
                    done <= 1'b1;
                    local_reset <= 1'b1;
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    done <= 1'b0;
                    local_reset <= 1'b0;
                    state <= ST_START;
                end
                default: state <= ST_START;
            endcase
        end
    end

    fill_area_engine engine_i (
        .clk(clk),
        .reset(engine_reset),
        .run(run),
        .ack(done),
        .req(req),
        .engine_done(engine_done),
        .wr(wr)
    );

    // Decoder drops enable right after the done pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done && !enable);

endmodule

// ==== src/framebuffer_ram.sv ====
/* Byte-wide frame store, contents undefined until the first blank.
   Read data follows the address by one cycle. */
`timescale 1ns/1ps
`include "panel_macros.svh"

module framebuffer_ram (
    input  logic clk,
    fb_write_if.memory wr,
    input  panel_pkg::row_t rd_row,
    input  panel_pkg::column_t rd_column,
    input  panel_pkg::pixel_t rd_pixel,
    output logic [7:0] rd_data
);
    localparam int DEPTH = `PANEL_HEIGHT * `PANEL_WIDTH * `BYTES_PER_PIXEL;
    localparam int ADDR_W = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];
    logic [ADDR_W-1:0] wr_addr, rd_addr;

    // Row major, pixel bytes adjacent
    function automatic logic [ADDR_W-1:0] addr_of(panel_pkg::row_t row,
                                                  panel_pkg::column_t column,
                                                  panel_pkg::pixel_t pixel);
        return ADDR_W'((int'(row) * `PANEL_WIDTH + int'(column)) * `BYTES_PER_PIXEL
                       + int'(pixel));
    endfunction

    assign wr_addr = addr_of(wr.row, wr.column, wr.pixel);
    assign rd_addr = addr_of(rd_row, rd_column, rd_pixel);

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            mem[wr_addr] <= wr.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== src/panel_cmd_top.sv ====
/* Command byte in, frame bytes out. All logic on clk, no back-pressure
   on cmd_valid; bytes seen while busy are lost. */
`timescale 1ns/1ps

module panel_cmd_top (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] cmd_byte,
    input  logic cmd_valid,
    output logic busy,
    output logic cmd_done,
    input  panel_pkg::row_t rd_row,
    input  panel_pkg::column_t rd_column,
    input  panel_pkg::pixel_t rd_pixel,
    output logic [7:0] rd_data
);
    logic fill_enable;
    logic fill_done;
    panel_pkg::fill_req_t fill_req;

    fb_write_if fb_wr ();

    cmd_decoder decoder_i (
        .clk(clk),
        .reset(reset),
        .cmd_byte(cmd_byte),
        .cmd_valid(cmd_valid),
        .fill_done(fill_done),
        .fill_enable(fill_enable),
        .fill_req(fill_req),
        .busy(busy),
        .cmd_done(cmd_done)
    );

    area_fill_cmd fill_cmd_i (
        .clk(clk),
        .reset(reset),
        .enable(fill_enable),
        .req(fill_req),
        .done(fill_done),
        .wr(fb_wr.writer)
    );

    framebuffer_ram fb_i (
        .clk(clk),
        .wr(fb_wr.memory),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

endmodule

// ==== dv/panel_ref_tasks.svh ====
/* Mirror model, command send tasks and readback for tb_panel_cmd.
   Included inside the testbench module, uses its clock and DUT signals. */
`ifndef PANEL_REF_TASKS_SVH
`define PANEL_REF_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
        $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
        errors++;
    end
endtask

// Clips like the decoder, returns 1 when the command should run
function automatic bit apply_fill(input int x1, input int y1, input int w, input int h,
                                  input panel_pkg::color_t color);
    int eff_w;
    int eff_h;
    if (x1 >= `PANEL_WIDTH || y1 >= `PANEL_HEIGHT || w == 0 || h == 0) return 1'b0;
    eff_w = (w < `PANEL_WIDTH - x1) ? w : `PANEL_WIDTH - x1;
    eff_h = (h < `PANEL_HEIGHT - y1) ? h : `PANEL_HEIGHT - y1;
    for (int r = y1; r < y1 + eff_h; r++) begin
        for (int c = x1; c < x1 + eff_w; c++) begin
            for (int p = 0; p < `BYTES_PER_PIXEL; p++) mirror[r][c][p] = color[p];
        end
    end
    return 1'b1;
endfunction

task automatic send_byte(input logic [7:0] b);
    @(posedge clk);
    cmd_byte <= b;
    cmd_valid <= 1'b1;
endtask

task automatic end_bytes();
    @(posedge clk);
    cmd_valid <= 1'b0;
endtask

task automatic wait_done();
    int cycles;
    bit seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
        if (cmd_done === 1'b1) begin
            seen = 1'b1;
            check_value("busy", 1, busy);   // Still busy during the pulse
        end
    end
    if (!seen) begin
        $display("Timeout: cmd_done did not arrive within %0d cycles", DONE_TIMEOUT);
        errors++;
    end
endtask

task automatic expect_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("cmd_done", 0, cmd_done);
    end
endtask

task automatic send_fill(input int x1, input int y1, input int w, input int h,
                         input panel_pkg::color_t color);
    bit runs;
    send_byte(panel_pkg::OP_FILL);
    send_byte(8'(x1));
    send_byte(8'(y1));
    send_byte(8'(w));
    send_byte(8'(h));
    for (int p = 0; p < `BYTES_PER_PIXEL; p++) send_byte(color[p]);
    end_bytes();
    runs = apply_fill(x1, y1, w, h, color);
    if (runs) begin
        wait_done();
        expect_idle(4);
    end else begin
        expect_idle(IDLE_WINDOW);
    end
endtask

// Read address goes out one cycle ahead of the compare
task automatic readback_compare();
    int r;
    int c;
    int p;
    for (int idx = 0; idx <= FB_BYTES; idx++) begin
        @(posedge clk);
        if (idx < FB_BYTES) begin
            rd_row <= panel_pkg::row_t'(idx / (`PANEL_WIDTH * `BYTES_PER_PIXEL));
            rd_column <= panel_pkg::column_t'((idx / `BYTES_PER_PIXEL) % `PANEL_WIDTH);
            rd_pixel <= panel_pkg::pixel_t'(idx % `BYTES_PER_PIXEL);
        end
        @(negedge clk);
        if (idx > 0) begin
            r = (idx - 1) / (`PANEL_WIDTH * `BYTES_PER_PIXEL);
            c = ((idx - 1) / `BYTES_PER_PIXEL) % `PANEL_WIDTH;
            p = (idx - 1) % `BYTES_PER_PIXEL;
            check_value($sformatf("rd_data[%0d][%0d][%0d]", r, c, p), mirror[r][c][p],
                        rd_data);
        end
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
        $display("Test %0d %s: ok", tests_run, name);
    end else begin
        tests_failed++;
        $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
endtask

`endif

// ==== dv/tb_panel_cmd.sv ====
/* Testbench for panel_cmd_top, checks every command against a byte mirror
   of the frame with a full readback after each test. */
`timescale 1ns/1ps
`include "panel_macros.svh"

module tb_panel_cmd;

    localparam int FB_BYTES = `PANEL_HEIGHT * `PANEL_WIDTH * `BYTES_PER_PIXEL;
    localparam int DONE_TIMEOUT = FB_BYTES + 100;
    localparam int IDLE_WINDOW = 200;   // Cycles with no cmd_done expected

    logic clk;
    logic reset;
    logic [7:0] cmd_byte;
    logic cmd_valid;
    logic busy;
    logic cmd_done;
    panel_pkg::row_t rd_row;
    panel_pkg::column_t rd_column;
    panel_pkg::pixel_t rd_pixel;
    logic [7:0] rd_data;

    logic [7:0] mirror [`PANEL_HEIGHT][`PANEL_WIDTH][`BYTES_PER_PIXEL];
    int errors = 0;
    int checks = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    integer seed = 32'h29c5_4f4c;

    `include "panel_ref_tasks.svh"

    panel_cmd_top panel_cmd_top_i (
        .clk(clk), .reset(reset),
        .cmd_byte(cmd_byte), .cmd_valid(cmd_valid),
        .busy(busy), .cmd_done(cmd_done),
        .rd_row(rd_row), .rd_column(rd_column), .rd_pixel(rd_pixel),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int rx;
        int ry;
        int rw;
        int rh;
        panel_pkg::color_t rcolor;
        reset <= 1'b1;
        cmd_byte <= 8'h00;
        cmd_valid <= 1'b0;
        rd_row <= '0;
        rd_column <= '0;
        rd_pixel <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("cmd_done", 0, cmd_done);
        send_byte(panel_pkg::OP_BLANK);
        end_bytes();
        void'(apply_fill(0, 0, `PANEL_WIDTH, `PANEL_HEIGHT, '0));
        wait_done();
        expect_idle(20);    // A second pulse would show here
        readback_compare();
        finish_test("blank after reset");

        send_fill(10, 5, 7, 4, {8'h33, 8'h22, 8'h11});
        readback_compare();
        finish_test("in-bounds fill");

        send_fill(`PANEL_WIDTH - 4, `PANEL_HEIGHT - 3, 20, 10, {8'hc6, 8'h5a, 8'h9e});
        readback_compare();
        finish_test("clipped fill");

        send_byte(8'h5a);
        end_bytes();
        expect_idle(IDLE_WINDOW);
        send_fill(`PANEL_WIDTH, 0, 4, 4, {8'hff, 8'hee, 8'hdd});
        send_fill(3, `PANEL_HEIGHT + 2, 4, 4, {8'hff, 8'hee, 8'hdd});
        send_fill(5, 5, 0, 3, {8'hff, 8'hee, 8'hdd});
        send_fill(5, 5, 3, 0, {8'hff, 8'hee, 8'hdd});
        readback_compare();
        finish_test("ignored commands");

        // Fill bytes land while the blank keeps busy high
        send_byte(panel_pkg::OP_BLANK);
        send_byte(panel_pkg::OP_FILL);
        send_byte(8'd2);
        send_byte(8'd2);
        send_byte(8'd6);
        send_byte(8'd6);
        for (int p = 0; p < `BYTES_PER_PIXEL; p++) send_byte(8'h77);
        end_bytes();
        void'(apply_fill(0, 0, `PANEL_WIDTH, `PANEL_HEIGHT, '0));
        wait_done();
        expect_idle(20);
        readback_compare();
        finish_test("bytes dropped while busy");

        for (int n = 0; n < 20; n++) begin
            rx = $unsigned($random(seed)) % (`PANEL_WIDTH + 4);
            ry = $unsigned($random(seed)) % (`PANEL_HEIGHT + 4);
            rw = $unsigned($random(seed)) % 24;
            rh = $unsigned($random(seed)) % 16;
            rcolor = panel_pkg::color_t'($random(seed));
            send_fill(rx, ry, rw, rh, rcolor);
        end
        readback_compare();
        finish_test("random fills");

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+src
+incdir+dv
src/panel_pkg.sv
src/fb_write_if.sv
src/cmd_decoder.sv
src/fill_area_engine.sv
src/area_fill_cmd.sv
src/framebuffer_ram.sv
src/panel_cmd_top.sv
dv/tb_panel_cmd.sv

// ==== Bender.yml ====
package:
  name: panel_cmd

sources:
  - include_dirs:
      - src
    files:
      - src/panel_pkg.sv
      - src/fb_write_if.sv
      - src/cmd_decoder.sv
      - src/fill_area_engine.sv
      - src/area_fill_cmd.sv
      - src/framebuffer_ram.sv
      - src/panel_cmd_top.sv
  - target: test
    include_dirs:
      - src
      - dv
    files:
      - dv/tb_panel_cmd.sv
